// File: common/hwce_pkg.sv
// convolution engine shared definitions
package hwce_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int FILTER_SIZE = 5;
  localparam int TAP_IDX_W   = $clog2(FILTER_SIZE);
  localparam int SAMPLE_W    = 16;
  localparam int PROD_W      = 2 * SAMPLE_W;
  localparam int ACC_W       = 40;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int ID_W        = 16;
  localparam int CNT_W       = 16;
  localparam int QF_W        = 4;
  localparam int REG_IDX_W   = 3;

  // output saturation bounds at accumulator width
  localparam logic signed [ACC_W-1:0] Y_MAX = 2 ** (SAMPLE_W - 1) - 1;
  localparam logic signed [ACC_W-1:0] Y_MIN = -(2 ** (SAMPLE_W - 1));

  ////////////////////
  // register map
  ////////////////////
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam reg_idx_t REG_TRIGGER     = 3'd0;
  localparam reg_idx_t REG_STATUS      = 3'd1;
  localparam reg_idx_t REG_WEIGHT_ADDR = 3'd2;
  localparam reg_idx_t REG_N_OUT       = 3'd3;
  localparam reg_idx_t REG_QF          = 3'd4;
  localparam reg_idx_t REG_BIAS        = 3'd5;
  localparam reg_idx_t REG_CTRL        = 3'd6;

  ////////////////////
  // types
  ////////////////////
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef sample_t [FILTER_SIZE-1:0]  weights_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
  } cfg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
  } cfg_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] weight_addr;
    logic [CNT_W-1:0]  n_out;
    logic [QF_W-1:0]   qf;
    sample_t           bias;
    logic              rectify;
  } job_cfg_t;

endpackage

// File: design/hwce_cfg_regs.sv
// configuration register file
module hwce_cfg_regs (
  input  logic               clk_fast_i,
  input  logic               rst_n,
  input  logic               cfg_req_i,
  input  hwce_pkg::cfg_req_t cfg_req_data_i,
  output logic               cfg_gnt_o,
  output logic               cfg_r_valid_o,
  output hwce_pkg::cfg_rsp_t cfg_rsp_o,
  input  logic               job_done_i,
  output logic               start_o,
  output logic               busy_o,
  output hwce_pkg::job_cfg_t job_o,
  output logic               evt_interrupt_o
);
  import hwce_pkg::*;

  reg_idx_t          reg_idx;
  logic              wr_en;
  logic [DATA_W-1:0] rdata;
  job_cfg_t          job_q;
  logic              busy_q;
  logic              evt_q;
  logic              r_valid_q;
  cfg_rsp_t          rsp_q;

  // target never stalls
  assign cfg_gnt_o = cfg_req_i;

  assign reg_idx = cfg_req_data_i.addr[REG_IDX_W+1:2];
  assign wr_en   = cfg_req_i && cfg_req_data_i.we;

  // trigger only counts while idle
  assign start_o = wr_en && (reg_idx == REG_TRIGGER) && !busy_q;

  always_comb begin
    case (reg_idx)
      REG_STATUS:      rdata = DATA_W'(busy_q);
      REG_WEIGHT_ADDR: rdata = job_q.weight_addr;
      REG_N_OUT:       rdata = DATA_W'(job_q.n_out);
      REG_QF:          rdata = DATA_W'(job_q.qf);
      REG_BIAS:        rdata = DATA_W'(job_q.bias);
      REG_CTRL:        rdata = DATA_W'(job_q.rectify);
      default:         rdata = '0;
    endcase
  end

  ////////////////////
  // job registers
  ////////////////////
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      job_q <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        REG_WEIGHT_ADDR: job_q.weight_addr <= cfg_req_data_i.data;
        REG_N_OUT:       job_q.n_out       <= cfg_req_data_i.data[CNT_W-1:0];
        REG_QF:          job_q.qf          <= cfg_req_data_i.data[QF_W-1:0];
        REG_BIAS:        job_q.bias        <= sample_t'(cfg_req_data_i.data[SAMPLE_W-1:0]);
        REG_CTRL:        job_q.rectify     <= cfg_req_data_i.data[0];
        default: ;
      endcase
    end
  end

  ////////////////////
  // busy and event
  ////////////////////
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      evt_q     <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= cfg_req_i;
      evt_q     <= busy_q && job_done_i;
      if (start_o) begin
        busy_q <= 1'b1;
      end else if (job_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // response one cycle after the grant with zero data for writes
  always_ff @(posedge clk_fast_i) begin
    if (cfg_req_i) begin
      rsp_q.data <= cfg_req_data_i.we ? '0 : rdata;
      rsp_q.id   <= cfg_req_data_i.id;
    end
  end

  assign cfg_r_valid_o   = r_valid_q;
  assign cfg_rsp_o       = rsp_q;
  assign busy_o          = busy_q;
  assign job_o           = job_q;
  assign evt_interrupt_o = evt_q;

  // the engine only finishes a job that busy covers
  a_done_in_job: assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    job_done_i |-> busy_o);

endmodule

// File: design/hwce_weight_loader.sv
// filter weight loader
module hwce_weight_loader (
  input  logic                        clk_fast_i,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic [hwce_pkg::ADDR_W-1:0] weight_addr_i,
  output logic                        mem_req_o,
  output hwce_pkg::mem_req_t          mem_req_data_o,
  input  logic                        mem_gnt_i,
  input  logic                        mem_r_valid_i,
  input  logic [hwce_pkg::DATA_W-1:0] mem_r_data_i,
  output hwce_pkg::weights_t          weights_o,
  output logic                        weights_done_o
);
  import hwce_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_t;

  state_t               state_q;
  logic [TAP_IDX_W-1:0] tap_q;
  logic [ADDR_W-1:0]    addr_q;
  logic                 done_q;
  logic                 last_rsp;
  weights_t             weights_q;

  assign last_rsp = (state_q == ST_WAIT) && mem_r_valid_i &&
                    (tap_q == TAP_IDX_W'(FILTER_SIZE - 1));

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      tap_q   <= '0;
      addr_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= last_rsp;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            addr_q  <= weight_addr_i;
            tap_q   <= '0;
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (mem_gnt_i) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (last_rsp) begin
            state_q <= ST_IDLE;
          end else if (mem_r_valid_i) begin
            // next word
            tap_q   <= tap_q + 1'b1;
            addr_q  <= addr_q + ADDR_W'(DATA_W / 8);
            state_q <= ST_REQ;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // low half of each word is one tap
  always_ff @(posedge clk_fast_i) begin
    if (state_q == ST_WAIT && mem_r_valid_i) begin
      weights_q[tap_q] <= sample_t'(mem_r_data_i[SAMPLE_W-1:0]);
    end
  end

  assign mem_req_o           = (state_q == ST_REQ);
  assign mem_req_data_o.addr = addr_q;
  assign weights_o           = weights_q;
  assign weights_done_o      = done_q;

  a_req_stable: assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_req_data_o));

endmodule

// File: engine/hwce_window.sv
// input sample window
module hwce_window (
  input  logic                       clk_fast_i,
  input  logic                       rst_n,
  input  logic                       weights_done_i,
  input  logic [hwce_pkg::CNT_W-1:0] n_out_i,
  input  logic                       x_in_valid_i,
  input  hwce_pkg::sample_t          x_in_data_i,
  output logic                       x_in_ready_o,
  output logic                       win_valid_o,
  output hwce_pkg::weights_t         win_o,
  input  logic                       win_ready_i,
  input  logic                       out_fire_i,
  output logic                       job_done_o
);
  import hwce_pkg::*;

  logic                       active_q;
  logic [CNT_W-1:0]           in_cnt_q;
  logic [CNT_W-1:0]           out_cnt_q;
  sample_t [FILTER_SIZE-2:0]  hist_q;
  logic                       more_in;
  logic                       in_fire;

  assign more_in      = active_q && (in_cnt_q != n_out_i);
  assign win_valid_o  = x_in_valid_i && more_in;
  assign x_in_ready_o = win_ready_i && more_in;
  assign in_fire      = x_in_valid_i && x_in_ready_o;

  // newest sample sits at tap 0
  assign win_o = {hist_q, x_in_data_i};

  assign job_done_o = active_q && out_fire_i && (out_cnt_q == n_out_i - 1'b1);

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      in_cnt_q  <= '0;
      out_cnt_q <= '0;
    end else if (weights_done_i) begin
      active_q  <= 1'b1;
      in_cnt_q  <= '0;
      out_cnt_q <= '0;
    end else begin
      if (in_fire) begin
        in_cnt_q <= in_cnt_q + 1'b1;
      end
      if (out_fire_i) begin
        out_cnt_q <= out_cnt_q + 1'b1;
      end
      if (job_done_o) begin
        active_q <= 1'b0;
      end
    end
  end

  // samples before the first one count as zero
  always_ff @(posedge clk_fast_i) begin
    if (weights_done_i) begin
      hist_q <= '0;
    end else if (in_fire) begin
      hist_q <= win_o[FILTER_SIZE-2:0];
    end
  end

endmodule

// File: engine/hwce_sop.sv
// sum-of-products pipeline
module hwce_sop (
  input  logic               clk_fast_i,
  input  logic               rst_n,
  input  hwce_pkg::weights_t weights_i,
  input  hwce_pkg::job_cfg_t job_i,
  input  logic               win_valid_i,
  input  hwce_pkg::weights_t win_i,
  output logic               win_ready_o,
  output logic               y_out_valid_o,
  output hwce_pkg::sample_t  y_out_data_o,
  input  logic               y_out_ready_i,
  output logic               out_fire_o
);
  import hwce_pkg::*;

  logic                     advance;
  logic                     valid_s1_q;
  logic                     valid_s2_q;
  logic signed [PROD_W-1:0] prod_q [FILTER_SIZE];
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  scaled;
  sample_t                  y_d;
  sample_t                  y_q;

  // full output stage with no taker freezes both stages
  assign advance     = !(valid_s2_q && !y_out_ready_i);
  assign win_ready_o = advance;

  ////////////////////
  // stage one
  ////////////////////
  always_ff @(posedge clk_fast_i) begin
    if (advance) begin
      for (int k = 0; k < FILTER_SIZE; k++) begin
        prod_q[k] <= $signed(weights_i[k]) * $signed(win_i[k]);
      end
    end
  end

  ////////////////////
  // stage two
  ////////////////////
  always_comb begin
    acc = '0;
    for (int k = 0; k < FILTER_SIZE; k++) begin
      acc = acc + ACC_W'(prod_q[k]);
    end
    scaled = (acc >>> job_i.qf) + ACC_W'(job_i.bias);
    // rectifier
    if (job_i.rectify && scaled < 0) begin
      scaled = '0;
    end
    if (scaled > Y_MAX) begin
      y_d = sample_t'(Y_MAX[SAMPLE_W-1:0]);
    end else if (scaled < Y_MIN) begin
      y_d = sample_t'(Y_MIN[SAMPLE_W-1:0]);
    end else begin
      y_d = sample_t'(scaled[SAMPLE_W-1:0]);
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (advance) begin
      y_q <= y_d;
    end
  end

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1_q <= 1'b0;
      valid_s2_q <= 1'b0;
    end else if (advance) begin
      valid_s1_q <= win_valid_i;
      valid_s2_q <= valid_s1_q;
    end
  end

  assign y_out_valid_o = valid_s2_q;
  assign y_out_data_o  = y_q;
  assign out_fire_o    = valid_s2_q && y_out_ready_i;

  a_y_hold: assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    y_out_valid_o && !y_out_ready_i |=> y_out_valid_o && $stable(y_out_data_o));

endmodule

// File: design/hwce_top.sv
// convolution engine top level
module hwce_top (
  input  logic                            clk_fast_i,
  input  logic                            rst_n,
  input  logic                            cfg_req_i,
  input  hwce_pkg::cfg_req_t              cfg_req_data_i,
  output logic                            cfg_gnt_o,
  output logic                            cfg_r_valid_o,
  output hwce_pkg::cfg_rsp_t              cfg_rsp_o,
  output logic                            evt_interrupt_o,
  output logic                            mem_req_o,
  output hwce_pkg::mem_req_t              mem_req_data_o,
  input  logic                            mem_gnt_i,
  input  logic                            mem_r_valid_i,
  input  logic [hwce_pkg::DATA_W-1:0]     mem_r_data_i,
  input  logic                            x_in_valid_i,
  input  hwce_pkg::sample_t               x_in_data_i,
  output logic                            x_in_ready_o,
  output logic                            y_out_valid_o,
  output hwce_pkg::sample_t               y_out_data_o,
  input  logic                            y_out_ready_i
);
  import hwce_pkg::*;

  job_cfg_t job;
  logic     start;
  logic     job_done;
  weights_t weights;
  logic     weights_done;
  logic     win_valid;
  logic     win_ready;
  weights_t win;
  logic     out_fire;

  hwce_cfg_regs cfg_regs_i (
    .clk_fast_i      (clk_fast_i),
    .rst_n           (rst_n),
    .cfg_req_i       (cfg_req_i),
    .cfg_req_data_i  (cfg_req_data_i),
    .cfg_gnt_o       (cfg_gnt_o),
    .cfg_r_valid_o   (cfg_r_valid_o),
    .cfg_rsp_o       (cfg_rsp_o),
    .job_done_i      (job_done),
    .start_o         (start),
    .busy_o          (),
    .job_o           (job),
    .evt_interrupt_o (evt_interrupt_o)
  );

  hwce_weight_loader weight_loader_i (
    .clk_fast_i     (clk_fast_i),
    .rst_n          (rst_n),
    .start_i        (start),
    .weight_addr_i  (job.weight_addr),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_data_i   (mem_r_data_i),
    .weights_o      (weights),
    .weights_done_o (weights_done)
  );

  hwce_window window_i (
    .clk_fast_i     (clk_fast_i),
    .rst_n          (rst_n),
    .weights_done_i (weights_done),
    .n_out_i        (job.n_out),
    .x_in_valid_i   (x_in_valid_i),
    .x_in_data_i    (x_in_data_i),
    .x_in_ready_o   (x_in_ready_o),
    .win_valid_o    (win_valid),
    .win_o          (win),
    .win_ready_i    (win_ready),
    .out_fire_i     (out_fire),
    .job_done_o     (job_done)
  );

  hwce_sop sop_i (
    .clk_fast_i    (clk_fast_i),
    .rst_n         (rst_n),
    .weights_i     (weights),
    .job_i         (job),
    .win_valid_i   (win_valid),
    .win_i         (win),
    .win_ready_o   (win_ready),
    .y_out_valid_o (y_out_valid_o),
    .y_out_data_o  (y_out_data_o),
    .y_out_ready_i (y_out_ready_i),
    .out_fire_o    (out_fire)
  );

endmodule

// File: verification/hwce_tb_mem.sv
// weight memory model
module hwce_tb_mem #(
  parameter int SEED = 0
) (
  input  logic                        clk_fast_i,
  input  logic                        rst_n,
  input  logic                        mem_req_i,
  input  hwce_pkg::mem_req_t          mem_req_data_i,
  output logic                        mem_gnt_o,
  output logic                        mem_r_valid_o,
  output logic [hwce_pkg::DATA_W-1:0] mem_r_data_o
);
  timeunit 1ns;
  timeprecision 1ns;
  import hwce_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_GRANTED,
    M_RSP
  } mem_state_t;

  // word array, filled by the testbench through the hierarchy
  logic [DATA_W-1:0] words [16];
  integer            seed = SEED;
  mem_state_t        state_q;
  logic [1:0]        delay_q;
  logic [3:0]        idx_q;

  always @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= M_IDLE;
      delay_q       <= '0;
      idx_q         <= '0;
      mem_gnt_o     <= 1'b0;
      mem_r_valid_o <= 1'b0;
      mem_r_data_o  <= '0;
    end else begin
      mem_gnt_o     <= 1'b0;
      mem_r_valid_o <= 1'b0;
      case (state_q)
        M_IDLE: begin
          if (mem_req_i && delay_q == 2'd0) begin
            mem_gnt_o <= 1'b1;
            idx_q     <= mem_req_data_i.addr[5:2];
            delay_q   <= 2'($random(seed));
            state_q   <= M_GRANTED;
          end else if (mem_req_i) begin
            delay_q <= delay_q - 2'd1;
          end
        end
        // data follows one cycle after the grant
        M_GRANTED: begin
          mem_r_valid_o <= 1'b1;
          mem_r_data_o  <= words[idx_q];
          state_q       <= M_RSP;
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

endmodule

// File: verification/hwce_tb.sv
// convolution engine testbench
module hwce_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import hwce_pkg::*;

  localparam logic [31:0] WEIGHT_BASE = 32'h0000_0010;
  localparam int          WBASE_WORD  = 4;

  logic     clk_fast = 1'b0;
  logic     rst_n;
  logic     cfg_req;
  cfg_req_t cfg_req_data;
  logic     cfg_gnt;
  logic     cfg_r_valid;
  cfg_rsp_t cfg_rsp;
  logic     evt;
  logic     mem_req;
  mem_req_t mem_req_data;
  logic     mem_gnt;
  logic     mem_r_valid;
  logic [DATA_W-1:0] mem_r_data;
  logic     x_valid;
  sample_t  x_data;
  logic     x_ready;
  logic     y_valid;
  sample_t  y_data;
  logic     y_ready = 1'b0;
  logic     y_fire;
  sample_t  exp_head;

  integer      seed = 32'h20aaac70;
  logic [31:0] exp_rdata = '0;
  logic [15:0] id_next = '0;
  logic        rect_on = 1'b0;
  logic        ready_gaps = 1'b0;
  int          exp_total = 0;
  int          in_limit = 0;
  int          in_total = 0;
  int          out_total = 0;
  int          evt_total = 0;
  int          gnt_total = 0;
  int          jobs_run = 0;
  int          sat_hits = 0;
  sample_t     wts [FILTER_SIZE];
  sample_t     xs [32];
  sample_t     exp_y [128];

  always #10 clk_fast = ~clk_fast;

  hwce_top dut0 (
    .clk_fast_i (clk_fast), .rst_n (rst_n),
    .cfg_req_i (cfg_req), .cfg_req_data_i (cfg_req_data), .cfg_gnt_o (cfg_gnt),
    .cfg_r_valid_o (cfg_r_valid), .cfg_rsp_o (cfg_rsp), .evt_interrupt_o (evt),
    .mem_req_o (mem_req), .mem_req_data_o (mem_req_data), .mem_gnt_i (mem_gnt),
    .mem_r_valid_i (mem_r_valid), .mem_r_data_i (mem_r_data),
    .x_in_valid_i (x_valid), .x_in_data_i (x_data), .x_in_ready_o (x_ready),
    .y_out_valid_o (y_valid), .y_out_data_o (y_data), .y_out_ready_i (y_ready)
  );

  hwce_tb_mem #(.SEED(32'h20aaac70)) mem0 (
    .clk_fast_i (clk_fast), .rst_n (rst_n), .mem_req_i (mem_req),
    .mem_req_data_i (mem_req_data), .mem_gnt_o (mem_gnt),
    .mem_r_valid_o (mem_r_valid), .mem_r_data_o (mem_r_data)
  );

  assign y_fire   = y_valid && y_ready;
  assign exp_head = exp_y[out_total[6:0]];

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // y[n] from the weights and the current sample history
  function automatic sample_t expected_output(input int n, input int q, input sample_t b,
                                              input logic rect);
    longint acc;
    acc = 0;
    for (int k = 0; k < FILTER_SIZE; k++) begin
      if (n - k >= 0) begin
        acc = acc + longint'(wts[k]) * longint'(xs[n-k]);
      end
    end
    acc = (acc >>> q) + longint'(b);
    if (rect && acc < 0) begin
      acc = 0;
    end
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    return sample_t'(acc);
  endfunction

  ////////////////////
  // monitors
  ////////////////////
  always @(posedge clk_fast) begin
    if (ready_gaps) begin
      y_ready <= ($random(seed) % 4) != 0;
    end else begin
      y_ready <= 1'b1;
    end
  end

  always @(posedge clk_fast) begin
    if (rst_n) begin
      if (x_valid && x_ready) in_total <= in_total + 1;
      if (y_fire) out_total <= out_total + 1;
      if (evt) evt_total <= evt_total + 1;
      if (mem_req && mem_gnt) gnt_total <= gnt_total + 1;
    end
  end

  ////////////////////
  // checks
  ////////////////////
  a_gnt: assert property (@(posedge clk_fast) disable iff (!rst_n) cfg_gnt == cfg_req)
    else stop_on_error($sformatf("FAILED at %0t: grant differs from request", $time));
  a_rsp_time: assert property (@(posedge clk_fast) disable iff (!rst_n)
    cfg_r_valid == $past(cfg_req))
    else stop_on_error($sformatf("FAILED at %0t: response not one cycle after request", $time));
  a_rsp_id: assert property (@(posedge clk_fast) disable iff (!rst_n)
    cfg_req |=> cfg_rsp.id == $past(cfg_req_data.id))
    else stop_on_error($sformatf("FAILED at %0t: response id not echoed", $time));
  a_rsp_data: assert property (@(posedge clk_fast) disable iff (!rst_n)
    cfg_req |=> cfg_rsp.data == $past(exp_rdata))
    else stop_on_error($sformatf("FAILED at %0t: wrong register read data", $time));
  a_y_value: assert property (@(posedge clk_fast) disable iff (!rst_n)
    y_fire |-> y_data == exp_head)
    else stop_on_error($sformatf("FAILED at %0t: y_out differs from the model", $time));
  a_y_hold: assert property (@(posedge clk_fast) disable iff (!rst_n)
    y_valid && !y_ready |=> y_valid && $stable(y_data))
    else stop_on_error($sformatf("FAILED at %0t: y_out not held under stall", $time));
  a_y_count: assert property (@(posedge clk_fast) disable iff (!rst_n)
    y_fire |-> out_total < exp_total)
    else stop_on_error($sformatf("FAILED at %0t: more outputs than n_out", $time));
  a_x_count: assert property (@(posedge clk_fast) disable iff (!rst_n)
    x_ready |-> in_total < in_limit)
    else stop_on_error($sformatf("FAILED at %0t: x_in ready beyond n_out", $time));
  a_rect: assert property (@(posedge clk_fast) disable iff (!rst_n)
    y_valid && rect_on |-> !y_data[SAMPLE_W-1])
    else stop_on_error($sformatf("FAILED at %0t: negative output with rectifier", $time));
  a_evt_pulse: assert property (@(posedge clk_fast) disable iff (!rst_n) evt |=> !evt)
    else stop_on_error($sformatf("FAILED at %0t: event longer than one cycle", $time));
  a_evt_last: assert property (@(posedge clk_fast) disable iff (!rst_n)
    evt |-> out_total == exp_total)
    else stop_on_error($sformatf("FAILED at %0t: event before the last output", $time));

  ////////////////////
  // stimulus
  ////////////////////
  task automatic cfg_access(input reg_idx_t idx, input logic we, input logic [31:0] wdata,
                            input logic [31:0] rexp);
    int tmo;
    cfg_req      <= 1'b1;
    cfg_req_data <= '{addr: 32'(idx) << 2, we: we, data: wdata, id: id_next};
    exp_rdata    <= we ? 32'd0 : rexp;
    id_next = id_next + 16'd1;
    tmo = 0;
    do begin
      @(posedge clk_fast);
      tmo++;
      if (tmo > 20) stop_on_error("timeout waiting for the configuration grant");
    end while (!cfg_gnt);
    cfg_req <= 1'b0;
  endtask

  task automatic run_job(input int n, input int q, input sample_t b, input logic rect,
                         input logic gaps);
    int          tmo;
    int          base;
    logic [31:0] word;
    base = exp_total;
    for (int k = 0; k < FILTER_SIZE; k++) begin
      word = $random(seed);
      mem0.words[WBASE_WORD + k] = word;
      wts[k] = sample_t'(word[15:0]);
    end
    for (int i = 0; i < n; i++) begin
      xs[i] = sample_t'($random(seed));
      exp_y[base + i] = expected_output(i, q, b, rect);
      if (exp_y[base + i] == 16'sh7fff || exp_y[base + i] == -16'sh8000) sat_hits++;
    end
    rect_on    <= rect;
    ready_gaps <= gaps;
    cfg_access(REG_N_OUT, 1'b1, 32'(n), '0);
    cfg_access(REG_QF, 1'b1, 32'(q), '0);
    cfg_access(REG_BIAS, 1'b1, 32'(b), '0);
    cfg_access(REG_CTRL, 1'b1, 32'(rect), '0);
    cfg_access(REG_WEIGHT_ADDR, 1'b1, WEIGHT_BASE, '0);
    exp_total <= base + n;
    in_limit  <= base + n;
    cfg_access(REG_TRIGGER, 1'b1, 32'd1, '0);
    jobs_run++;
    for (int i = 0; i < n; i++) begin
      x_valid <= 1'b1;
      x_data  <= xs[i];
      tmo = 0;
      do begin
        @(posedge clk_fast);
        tmo++;
        if (tmo > 300) stop_on_error("timeout waiting for x_in to accept a sample");
      end while (!x_ready);
      // a second trigger in the middle of the job must be ignored
      if (i == n / 2) begin
        x_valid <= 1'b0;
        cfg_access(REG_TRIGGER, 1'b1, 32'd1, '0);
      end
    end
    x_valid <= 1'b0;
    tmo = 0;
    while (out_total != base + n || evt_total != jobs_run) begin
      @(posedge clk_fast);
      tmo++;
      if (tmo > 2000) stop_on_error("timeout waiting for the outputs and the event");
    end
    cfg_access(REG_STATUS, 1'b0, '0, 32'd0);
    @(posedge clk_fast);
    assert (evt_total == jobs_run && gnt_total == FILTER_SIZE * jobs_run)
      else stop_on_error("extra event pulse or extra weight fetch after a job");
  endtask

  initial begin
    rst_n        = 1'b0;
    cfg_req      = 1'b0;
    cfg_req_data = '0;
    x_valid      = 1'b0;
    x_data       = '0;
    repeat (16) @(posedge clk_fast);
    rst_n <= 1'b1;
    @(posedge clk_fast);
    // register readback
    cfg_access(REG_WEIGHT_ADDR, 1'b1, WEIGHT_BASE, '0);
    cfg_access(REG_WEIGHT_ADDR, 1'b0, '0, WEIGHT_BASE);
    cfg_access(REG_N_OUT, 1'b1, 32'h0000_1234, '0);
    cfg_access(REG_N_OUT, 1'b0, '0, 32'h0000_1234);
    cfg_access(REG_QF, 1'b1, 32'h0000_0009, '0);
    cfg_access(REG_QF, 1'b0, '0, 32'h0000_0009);
    cfg_access(REG_BIAS, 1'b1, 32'hffff_ff80, '0);
    cfg_access(REG_BIAS, 1'b0, '0, 32'hffff_ff80);
    cfg_access(REG_CTRL, 1'b1, 32'h0000_0001, '0);
    cfg_access(REG_CTRL, 1'b0, '0, 32'h0000_0001);
    cfg_access(REG_STATUS, 1'b0, '0, 32'd0);
    // plain convolution, then saturation, then rectifier with stalls
    run_job(20, 0, 16'sd0, 1'b0, 1'b0);
    run_job(20, 12, -16'sd300, 1'b0, 1'b0);
    assert (sat_hits > 0) else stop_on_error("no output reached the saturation limits");
    run_job(24, 14, -16'sd200, 1'b1, 1'b1);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: vlog.f
common/hwce_pkg.sv
design/hwce_cfg_regs.sv
design/hwce_weight_loader.sv
engine/hwce_window.sv
engine/hwce_sop.sv
design/hwce_top.sv
verification/hwce_tb_mem.sv
verification/hwce_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module hwce_tb -Mdir obj_dir

run: build
	./obj_dir/Vhwce_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module hwce_top

clean:
	rm -rf obj_dir sim.log
